// File: build.f
+incdir+testbench
hw/fdc_pkg.sv
hw/mcu_bus_sync.sv
hw/fdc_regs.sv
hw/sram_addr_counter.sv
hw/sram_write_ctrl.sv
hw/step_controller.sv
hw/fdc_top.sv
testbench/fdc_top_assert.sv
testbench/tb_fdc_top.sv

// File: hw/fdc_pkg.sv
package fdc_pkg;

	////////////////////////////////////////////////////////////
	// Bus types
	typedef logic [7:0]  byte_t;		// One MCU or SRAM bus byte
	typedef logic [18:0] sram_addr_t;	// 512K x 8 SRAM
	typedef logic [15:0] mcu_addr_t;	// Latched PMP address

	////////////////////////////////////////////////////////////
	// Register map, low address byte only
	localparam byte_t REG_ADDR_L      = 8'h00;	// Pointer bits 7..0
	localparam byte_t REG_ADDR_H      = 8'h01;	// Pointer bits 15..8
	localparam byte_t REG_ADDR_U      = 8'h02;	// Pointer bits 18..16
	localparam byte_t REG_SRAM_DATA   = 8'h03;	// SRAM byte at pointer

	// Write and read share 0x04
	localparam byte_t REG_DRIVE_CTRL  = 8'h04;
	localparam byte_t REG_MCO_TYPE_L  = 8'h04;
	localparam byte_t REG_MCO_TYPE_H  = 8'h05;
	localparam byte_t REG_MCO_VER_L   = 8'h06;
	localparam byte_t REG_MCO_VER_H   = 8'h07;

	localparam byte_t REG_STATUS2     = 8'h0F;
	localparam byte_t REG_SCRATCH     = 8'h30;	// Bus test pattern
	localparam byte_t REG_SCRATCH_INV = 8'h31;	// Same, inverted
	localparam byte_t REG_STEP_RATE   = 8'hF0;	// Period in ticks, minus one
	localparam byte_t REG_STEP_CMD    = 8'hFF;

	// Identity
	localparam logic [15:0] MCO_TYPE    = 16'hDD55;
	localparam logic [15:0] MCO_VERSION = 16'h001A;

	////////////////////////////////////////////////////////////
	// STATUS2 bit positions
	localparam int ST2_INDEX    = 7;
	localparam int ST2_TRACK0   = 6;
	localparam int ST2_WRPROT   = 5;
	localparam int ST2_READY    = 4;
	localparam int ST2_DENSITY  = 3;
	localparam int ST2_STEPPING = 2;
	localparam int ST2_EMPTY    = 1;
	localparam int ST2_FULL     = 0;

	// Step command byte
	localparam int STEP_DIR_BIT = 7;	// Set for inward
	localparam int STEP_CNT_MSB = 6;	// Count in bits 6..0

endpackage

// File: hw/fdc_regs.sv
`timescale 1ns/1ps

module fdc_regs (
	input  logic                CLK_MASTER,
	input  logic                rst_n,
	input  fdc_pkg::mcu_addr_t  mcu_addr,
	input  logic                wr_pulse,
	input  fdc_pkg::byte_t      wr_data,
	input  logic                rd_active,
	input  logic                rd_done,
	input  fdc_pkg::sram_addr_t sram_a,
	input  fdc_pkg::byte_t      sram_dq_in,
	input  logic                empty,
	input  logic                full,
	input  logic                stepping,
	input  logic                fd_index_in,
	input  logic                fd_track0_in,
	input  logic                fd_wrprot_in,
	input  logic                fd_rdy_dchg_in,
	input  logic                fd_dens_in,
	output fdc_pkg::byte_t      pmd_out,
	output logic                pmd_oe,
	output fdc_pkg::byte_t      sram_data_out,
	output logic                sram_wr_start,
	output logic                load_l,
	output logic                load_h,
	output logic                load_u,
	output fdc_pkg::byte_t      load_data,
	output logic                rd_inc,
	output logic                step_cmd_wr,
	output fdc_pkg::byte_t      step_cmd,
	output fdc_pkg::byte_t      step_rate,
	output logic                fd_dens_out,
	output logic                fd_inuse,
	output logic [3:0]          fd_drvsel,
	output logic                fd_moten,
	output logic                fd_sidesel
);
	import fdc_pkg::*;

	byte_t reg_sel;		// Decoded address byte
	byte_t drive_ctrl;
	byte_t scratch;
	byte_t status2;

	assign reg_sel = mcu_addr[7:0];

	////////////////////////////////////////////////////////////
	// Write decode
	assign sram_wr_start = wr_pulse && (reg_sel == REG_SRAM_DATA);
	assign load_l        = wr_pulse && (reg_sel == REG_ADDR_L);
	assign load_h        = wr_pulse && (reg_sel == REG_ADDR_H);
	assign load_u        = wr_pulse && (reg_sel == REG_ADDR_U);
	assign load_data     = wr_data;
	assign step_cmd_wr   = wr_pulse && (reg_sel == REG_STEP_CMD);
	assign step_cmd      = wr_data;	// Sampled by the stepper with the strobe

	// Pointer moves on once the MCU has taken the byte
	assign rd_inc = rd_done && (reg_sel == REG_SRAM_DATA);

	// Control registers
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			drive_ctrl <= '0;	// All drive lines inactive
			step_rate  <= '0;
		end else if (wr_pulse) begin
			if (reg_sel == REG_DRIVE_CTRL)
				drive_ctrl <= wr_data;
			if (reg_sel == REG_STEP_RATE)
				step_rate <= wr_data;
		end
	end

	// Data and scratch bytes
	always_ff @(posedge CLK_MASTER) begin
		if (wr_pulse && (reg_sel == REG_SRAM_DATA))
			sram_data_out <= wr_data;
		if (wr_pulse && (reg_sel == REG_SCRATCH))
			scratch <= wr_data;
	end

	////////////////////////////////////////////////////////////
	// Drive outputs, active low
	assign fd_dens_out = ~drive_ctrl[0];
	assign fd_inuse    = ~drive_ctrl[1];
	assign fd_drvsel   = ~drive_ctrl[5:2];
	assign fd_moten    = ~drive_ctrl[6];
	assign fd_sidesel  = ~drive_ctrl[7];

	////////////////////////////////////////////////////////////
	// Readback
	always_comb begin
		status2               = '0;
		status2[ST2_INDEX]    = fd_index_in;
		status2[ST2_TRACK0]   = fd_track0_in;
		status2[ST2_WRPROT]   = fd_wrprot_in;
		status2[ST2_READY]    = fd_rdy_dchg_in;
		status2[ST2_DENSITY]  = fd_dens_in;
		status2[ST2_STEPPING] = stepping;
		status2[ST2_EMPTY]    = empty;
		status2[ST2_FULL]     = full;
	end

	always_comb begin
		case (reg_sel)
			REG_ADDR_L:      pmd_out = sram_a[7:0];
			REG_ADDR_H:      pmd_out = sram_a[15:8];
			REG_ADDR_U:      pmd_out = {5'b0, sram_a[18:16]};
			REG_SRAM_DATA:   pmd_out = sram_dq_in;	// Live SRAM output
			REG_MCO_TYPE_L:  pmd_out = MCO_TYPE[7:0];
			REG_MCO_TYPE_H:  pmd_out = MCO_TYPE[15:8];
			REG_MCO_VER_L:   pmd_out = MCO_VERSION[7:0];
			REG_MCO_VER_H:   pmd_out = MCO_VERSION[15:8];
			REG_STATUS2:     pmd_out = status2;
			REG_SCRATCH:     pmd_out = scratch;
			REG_SCRATCH_INV: pmd_out = ~scratch;
			default:         pmd_out = 8'h00;	// Unmapped
		endcase
	end

	assign pmd_oe = rd_active;	// Every address answers a read

endmodule

// File: hw/fdc_top.sv
`timescale 1ns/1ps

module fdc_top #(
	parameter int clks_per_tick = 10000		// 250 us at 40 MHz
) (
	input  logic                CLK_MASTER,
	input  logic                rst_n,
	input  logic                mcu_pmalh,
	input  logic                mcu_pmall,
	input  logic                mcu_pmrd,
	input  logic                mcu_pmwr,
	input  logic                fd_index_in,
	input  logic                fd_track0_in,
	input  logic                fd_wrprot_in,
	input  logic                fd_rdy_dchg_in,
	input  logic                fd_dens_in,
	inout  wire fdc_pkg::byte_t mcu_pmd,
	inout  wire fdc_pkg::byte_t sram_dq,
	output fdc_pkg::sram_addr_t sram_a,
	output logic                sram_we_n,
	output logic                sram_oe_n,
	output logic                fd_step,
	output logic                fd_dir,
	output logic                fd_dens_out,
	output logic                fd_inuse,
	output logic [3:0]          fd_drvsel,
	output logic                fd_moten,
	output logic                fd_sidesel
);
	import fdc_pkg::*;

	// MCU side
	mcu_addr_t mcu_addr;
	logic      wr_pulse;
	byte_t     wr_data;
	logic      rd_active;
	logic      rd_done;
	byte_t     pmd_out;
	logic      pmd_oe;

	// SRAM side
	byte_t     sram_data_out;
	logic      sram_wr_start;
	byte_t     sram_dq_out;
	logic      sram_dq_oe;
	logic      load_l;
	logic      load_h;
	logic      load_u;
	byte_t     load_data;
	logic      wr_inc;
	logic      rd_inc;
	logic      empty;
	logic      full;

	// Stepper
	logic      step_cmd_wr;
	byte_t     step_cmd;
	byte_t     step_rate;
	logic      stepping;

	////////////////////////////////////////////////////////////
	// Bus tri-states
	assign mcu_pmd = pmd_oe ? pmd_out : 'z;
	assign sram_dq = sram_dq_oe ? sram_dq_out : 'z;

	////////////////////////////////////////////////////////////
	// Host interface
	mcu_bus_sync mcu_bus_sync_inst (
		.CLK_MASTER (CLK_MASTER),
		.rst_n      (rst_n),
		.mcu_pmalh  (mcu_pmalh),
		.mcu_pmall  (mcu_pmall),
		.mcu_pmrd   (mcu_pmrd),
		.mcu_pmwr   (mcu_pmwr),
		.pmd_in     (mcu_pmd),
		.mcu_addr   (mcu_addr),
		.wr_pulse   (wr_pulse),
		.wr_data    (wr_data),
		.rd_active  (rd_active),
		.rd_done    (rd_done)
	);

	fdc_regs fdc_regs_inst (
		.CLK_MASTER     (CLK_MASTER),
		.rst_n          (rst_n),
		.mcu_addr       (mcu_addr),
		.wr_pulse       (wr_pulse),
		.wr_data        (wr_data),
		.rd_active      (rd_active),
		.rd_done        (rd_done),
		.sram_a         (sram_a),
		.sram_dq_in     (sram_dq),
		.empty          (empty),
		.full           (full),
		.stepping       (stepping),
		.fd_index_in    (fd_index_in),
		.fd_track0_in   (fd_track0_in),
		.fd_wrprot_in   (fd_wrprot_in),
		.fd_rdy_dchg_in (fd_rdy_dchg_in),
		.fd_dens_in     (fd_dens_in),
		.pmd_out        (pmd_out),
		.pmd_oe         (pmd_oe),
		.sram_data_out  (sram_data_out),
		.sram_wr_start  (sram_wr_start),
		.load_l         (load_l),
		.load_h         (load_h),
		.load_u         (load_u),
		.load_data      (load_data),
		.rd_inc         (rd_inc),
		.step_cmd_wr    (step_cmd_wr),
		.step_cmd       (step_cmd),
		.step_rate      (step_rate),
		.fd_dens_out    (fd_dens_out),
		.fd_inuse       (fd_inuse),
		.fd_drvsel      (fd_drvsel),
		.fd_moten       (fd_moten),
		.fd_sidesel     (fd_sidesel)
	);

	////////////////////////////////////////////////////////////
	// SRAM path
	sram_addr_counter sram_addr_counter_inst (
		.CLK_MASTER (CLK_MASTER),
		.rst_n      (rst_n),
		.load_l     (load_l),
		.load_h     (load_h),
		.load_u     (load_u),
		.load_data  (load_data),
		.wr_inc     (wr_inc),
		.rd_inc     (rd_inc),
		.sram_a     (sram_a),
		.empty      (empty),
		.full       (full)
	);

	sram_write_ctrl sram_write_ctrl_inst (
		.CLK_MASTER    (CLK_MASTER),
		.rst_n         (rst_n),
		.sram_wr_start (sram_wr_start),
		.sram_data_out (sram_data_out),
		.sram_we_n     (sram_we_n),
		.sram_oe_n     (sram_oe_n),
		.sram_dq_out   (sram_dq_out),
		.sram_dq_oe    (sram_dq_oe),
		.wr_inc        (wr_inc)
	);

	////////////////////////////////////////////////////////////
	// Head stepper
	step_controller #(
		.clks_per_tick (clks_per_tick)
	) step_controller_inst (
		.CLK_MASTER   (CLK_MASTER),
		.rst_n        (rst_n),
		.step_rate    (step_rate),
		.step_cmd_wr  (step_cmd_wr),
		.step_cmd     (step_cmd),
		.fd_track0_in (fd_track0_in),
		.stepping     (stepping),
		.fd_step      (fd_step),
		.fd_dir       (fd_dir)
	);

endmodule

// File: hw/mcu_bus_sync.sv
`timescale 1ns/1ps

module mcu_bus_sync (
	input  logic               CLK_MASTER,
	input  logic               rst_n,
	input  logic               mcu_pmalh,	// Address high latch strobe
	input  logic               mcu_pmall,	// Address low latch strobe
	input  logic               mcu_pmrd,
	input  logic               mcu_pmwr,
	input  fdc_pkg::byte_t     pmd_in,
	output fdc_pkg::mcu_addr_t mcu_addr,
	output logic               wr_pulse,
	output fdc_pkg::byte_t     wr_data,
	output logic               rd_active,
	output logic               rd_done
);
	import fdc_pkg::*;

	// Bits 1..0 form the synchronizer, bit 2 holds the previous level
	logic [2:0] alh_sync;
	logic [2:0] all_sync;
	logic [2:0] rd_sync;
	logic [2:0] wr_sync;
	logic       alh_fall;
	logic       all_fall;
	logic       wr_rise;
	byte_t      addr_h;
	byte_t      addr_l;

	////////////////////////////////////////////////////////////
	// Strobe synchronizers
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			alh_sync <= '0;
			all_sync <= '0;
			rd_sync  <= '0;
			wr_sync  <= '0;
		end else begin
			alh_sync <= {alh_sync[1:0], mcu_pmalh};
			all_sync <= {all_sync[1:0], mcu_pmall};
			rd_sync  <= {rd_sync[1:0], mcu_pmrd};
			wr_sync  <= {wr_sync[1:0], mcu_pmwr};
		end
	end

	assign alh_fall = alh_sync[2] & ~alh_sync[1];
	assign all_fall = all_sync[2] & ~all_sync[1];
	assign wr_rise  = wr_sync[1] & ~wr_sync[2];
	assign rd_done  = rd_sync[2] & ~rd_sync[1];	// End of read cycle

	// Bus drive opens after one stage and drops as soon as pmrd releases
	assign rd_active = mcu_pmrd & rd_sync[0];

	////////////////////////////////////////////////////////////
	// Address latches
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			addr_h <= '0;
			addr_l <= '0;
		end else begin
			if (alh_fall)
				addr_h <= pmd_in;	// High byte
			if (all_fall)
				addr_l <= pmd_in;	// Low byte
		end
	end

	assign mcu_addr = {addr_h, addr_l};

	// Write strobe, one cycle per pmwr
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n)
			wr_pulse <= 1'b0;
		else
			wr_pulse <= wr_rise;
	end

	// Data is stable while pmwr is high
	always_ff @(posedge CLK_MASTER) begin
		if (wr_rise)
			wr_data <= pmd_in;
	end

endmodule

// File: hw/sram_addr_counter.sv
`timescale 1ns/1ps

module sram_addr_counter (
	input  logic                CLK_MASTER,
	input  logic                rst_n,
	input  logic                load_l,
	input  logic                load_h,
	input  logic                load_u,
	input  fdc_pkg::byte_t      load_data,
	input  logic                wr_inc,		// From the write FSM
	input  logic                rd_inc,		// From a data register read
	output fdc_pkg::sram_addr_t sram_a,
	output logic                empty,
	output logic                full
);
	import fdc_pkg::*;

	////////////////////////////////////////////////////////////
	// Pointer
	// Byte loads win over an increment
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n)
			sram_a <= '0;
		else if (load_l)
			sram_a[7:0] <= load_data;
		else if (load_h)
			sram_a[15:8] <= load_data;
		else if (load_u)
			sram_a[18:16] <= load_data[2:0];	// Top 3 bits only
		else if (wr_inc || rd_inc)
			sram_a <= sram_a + sram_addr_t'(1);	// Wraps at 512K
	end

	// Flags
	assign empty = (sram_a == '0);
	assign full  = &sram_a;

endmodule

// File: hw/sram_write_ctrl.sv
`timescale 1ns/1ps

module sram_write_ctrl (
	input  logic           CLK_MASTER,
	input  logic           rst_n,
	input  logic           sram_wr_start,
	input  fdc_pkg::byte_t sram_data_out,
	output logic           sram_we_n,
	output logic           sram_oe_n,
	output fdc_pkg::byte_t sram_dq_out,
	output logic           sram_dq_oe,
	output logic           wr_inc
);

	typedef enum logic [2:0] {
		S_IDLE,		// OE on, waiting for a write
		S_OE_OFF,	// SRAM outputs released
		S_WRITE,	// WE pulse
		S_WR_END,	// WE back high, byte stored
		S_INC		// Pointer advance
	} wr_state_t;

	wr_state_t state;

	////////////////////////////////////////////////////////////
	// Write cycle FSM
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;
			wr_inc    <= 1'b0;
		end else begin
			wr_inc <= 1'b0;
			case (state)
				S_IDLE: begin
					if (sram_wr_start) begin	// A start while busy is dropped
						state     <= S_OE_OFF;
						sram_oe_n <= 1'b1;
					end
				end
				S_OE_OFF: begin
					state     <= S_WRITE;
					sram_we_n <= 1'b0;
				end
				S_WRITE: begin
					state     <= S_WR_END;
					sram_we_n <= 1'b1;		// Rising WE latches the byte
				end
				S_WR_END: begin
					state  <= S_INC;
					wr_inc <= 1'b1;
				end
				S_INC: begin
					state     <= S_IDLE;
					sram_oe_n <= 1'b0;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Byte is settled by the time the FSM leaves idle
	always_ff @(posedge CLK_MASTER) begin
		if (state == S_OE_OFF)
			sram_dq_out <= sram_data_out;
	end

	assign sram_dq_oe = (state != S_IDLE);	// Same cycles as oe_n high

endmodule

// File: hw/step_controller.sv
`timescale 1ns/1ps

module step_controller #(
	parameter int clks_per_tick = 10000		// CLK_MASTER cycles per base tick
) (
	input  logic           CLK_MASTER,
	input  logic           rst_n,
	input  fdc_pkg::byte_t step_rate,
	input  logic           step_cmd_wr,
	input  fdc_pkg::byte_t step_cmd,
	input  logic           fd_track0_in,	// Active low
	output logic           stepping,
	output logic           fd_step,
	output logic           fd_dir
);
	import fdc_pkg::*;

	localparam int CNT_W = (clks_per_tick > 1) ? $clog2(clks_per_tick) : 1;

	typedef enum logic {ST_IDLE, ST_SEEK} seek_state_t;

	logic [CNT_W-1:0]      clk_cnt;
	logic                  tick;		// One cycle per base tick
	byte_t                 tick_cnt;	// Position in the step period
	logic [STEP_CNT_MSB:0] steps_left;
	logic [1:0]            trk0_sync;
	logic                  at_track0;
	seek_state_t           state;

	////////////////////////////////////////////////////////////
	// Base tick divider
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			clk_cnt <= '0;
			tick    <= 1'b0;
		end else if (clk_cnt == CNT_W'(clks_per_tick - 1)) begin
			clk_cnt <= '0;
			tick    <= 1'b1;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

	// Track 0 comes straight from the drive
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n)
			trk0_sync <= 2'b11;
		else
			trk0_sync <= {trk0_sync[0], fd_track0_in};
	end

	assign at_track0 = ~trk0_sync[1];

	////////////////////////////////////////////////////////////
	// Seek FSM
	// fd_dir doubles as the direction flag, high means outward
	always_ff @(posedge CLK_MASTER) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			tick_cnt   <= '0;
			steps_left <= '0;
			fd_step    <= 1'b1;
			fd_dir     <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					fd_step <= 1'b1;
					if (step_cmd_wr && (step_cmd[STEP_CNT_MSB:0] != '0)) begin
						state      <= ST_SEEK;
						steps_left <= step_cmd[STEP_CNT_MSB:0];
						fd_dir     <= ~step_cmd[STEP_DIR_BIT];	// Low for inward
						tick_cnt   <= '0;
					end
				end
				ST_SEEK: begin
					if (tick) begin
						fd_step <= 1'b1;		// Pulse lasts one tick
						if (tick_cnt == step_rate)
							tick_cnt <= '0;
						else
							tick_cnt <= tick_cnt + 1'b1;
						// Each period starts with a pulse or ends the seek
						if (tick_cnt == '0) begin
							if ((steps_left == '0) || (fd_dir && at_track0)) begin
								state <= ST_IDLE;
							end else begin
								fd_step    <= 1'b0;
								steps_left <= steps_left - 1'b1;
							end
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign stepping = (state == ST_SEEK);	// Commands ignored while set

endmodule

// File: testbench/fdc_top_assert.sv
`timescale 1ns/1ps

module fdc_top_assert (
	input logic CLK_MASTER,
	input logic rst_n,
	input logic sram_we_n,
	input logic sram_oe_n,
	input logic sram_dq_oe,
	input logic fd_step,
	input logic stepping
);

	int violations = 0;	// Read by the testbench at the end

	////////////////////////////////////////////////////////////
	// SRAM bus
	we_needs_oe_off: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!sram_we_n |-> sram_oe_n)
	else begin
		violations++;
		$error("SRAM we_n low while oe_n is low");
	end

	dq_drive_needs_oe_off: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		sram_dq_oe |-> sram_oe_n)
	else begin
		violations++;
		$error("SRAM data bus driven while oe_n is low");
	end

	// Step pulses only inside a seek
	step_only_when_seeking: assert property (@(posedge CLK_MASTER) disable iff (!rst_n)
		!fd_step |-> stepping)
	else begin
		violations++;
		$error("fd_step low while stepping is clear");
	end

endmodule

bind fdc_top fdc_top_assert fdc_top_assert_inst (
	.CLK_MASTER (CLK_MASTER),
	.rst_n      (rst_n),
	.sram_we_n  (sram_we_n),
	.sram_oe_n  (sram_oe_n),
	.sram_dq_oe (sram_dq_oe),
	.fd_step    (fd_step),
	.stepping   (stepping)
);

// File: testbench/tb_fdc_tests.svh
////////////////////////////////////////////////////////////
// MCU bus cycles, all driven on the falling edge

task automatic hold_cycles(input int n);
	repeat (n) @(negedge CLK_MASTER);
endtask

// High byte first, each held on the bus past its strobe fall
task automatic latch_addr(input mcu_addr_t addr);
	@(negedge CLK_MASTER);
	pmd_drv   = addr[15:8];
	pmd_en    = 1'b1;
	mcu_pmalh = 1'b1;
	hold_cycles(STROBE_CYCLES);
	mcu_pmalh = 1'b0;
	hold_cycles(STROBE_CYCLES);
	pmd_drv   = addr[7:0];
	mcu_pmall = 1'b1;
	hold_cycles(STROBE_CYCLES);
	mcu_pmall = 1'b0;
	hold_cycles(STROBE_CYCLES);
	pmd_en    = 1'b0;
endtask

task automatic bus_write(input byte_t data);
	@(negedge CLK_MASTER);
	pmd_drv  = data;
	pmd_en   = 1'b1;
	mcu_pmwr = 1'b1;
	hold_cycles(STROBE_CYCLES);
	mcu_pmwr = 1'b0;
	pmd_en   = 1'b0;
	hold_cycles(STROBE_CYCLES);	// Also covers the SRAM write cycle
endtask

task automatic bus_read(output byte_t data);
	@(negedge CLK_MASTER);
	pmd_en   = 1'b0;
	mcu_pmrd = 1'b1;
	hold_cycles(STROBE_CYCLES);
	data     = mcu_pmd;	// Sampled just before pmrd drops
	mcu_pmrd = 1'b0;
	hold_cycles(STROBE_CYCLES);
endtask

// Random high address byte, only the low byte is decoded
task automatic reg_write(input byte_t sel, input byte_t data);
	latch_addr({rand_byte(), sel});
	bus_write(data);
endtask

task automatic reg_read(input byte_t sel, output byte_t data);
	latch_addr({rand_byte(), sel});
	bus_read(data);
endtask

task automatic load_pointer(input sram_addr_t ptr);
	reg_write(REG_ADDR_L, ptr[7:0]);
	reg_write(REG_ADDR_H, ptr[15:8]);
	reg_write(REG_ADDR_U, {5'b0, ptr[18:16]});
endtask

task automatic read_pointer(output sram_addr_t ptr);
	byte_t lo;
	byte_t hi;
	byte_t up;
	reg_read(REG_ADDR_L, lo);
	reg_read(REG_ADDR_H, hi);
	reg_read(REG_ADDR_U, up);
	check_byte(up & 8'hF8, 8'h00, "unused pointer bits");
	ptr = {up[2:0], hi, lo};
endtask

// Polls STATUS2 until the seek is over
task automatic wait_seek_done(input logic dir_out);
	byte_t st;
	logic  seen;
	seen = 1'b0;
	latch_addr({8'h00, REG_STATUS2});
	do begin
		bus_read(st);
		if (st[ST2_STEPPING]) begin
			seen = 1'b1;
			check_byte({7'b0, fd_dir}, {7'b0, dir_out}, "fd_dir during seek");
		end
	end while (st[ST2_STEPPING]);
	if (!seen)
		abort_run("STATUS2 never showed the stepping bit after a seek command");
endtask

////////////////////////////////////////////////////////////
// Directed tests

task automatic test_identity();
	byte_t rd;
	byte_t pat;
	int    i;
	check_addr(sram_a, '0, "pointer after reset");
	check_byte(drive_lines(), 8'hFF, "drive outputs after reset");
	check_byte({5'b0, sram_we_n, sram_oe_n, fd_step}, 8'h05, "we_n, oe_n, step after reset");
	reg_read(REG_MCO_TYPE_L, rd);
	check_byte(rd, MCO_TYPE[7:0], "type low");
	reg_read(REG_MCO_TYPE_H, rd);
	check_byte(rd, MCO_TYPE[15:8], "type high");
	reg_read(REG_MCO_VER_L, rd);
	check_byte(rd, MCO_VERSION[7:0], "version low");
	reg_read(REG_MCO_VER_H, rd);
	check_byte(rd, MCO_VERSION[15:8], "version high");
	for (i = 0; i < 4; i++) begin
		pat = rand_byte();
		reg_write(REG_SCRATCH, pat);
		reg_read(REG_SCRATCH, rd);
		check_byte(rd, pat, "scratchpad");
		reg_read(REG_SCRATCH_INV, rd);
		check_byte(rd, ~pat, "inverse scratchpad");
	end
endtask

task automatic test_drive_ctrl();
	byte_t ctrl;
	int    i;
	for (i = 0; i < 4; i++) begin
		ctrl = rand_byte();
		reg_write(REG_DRIVE_CTRL, ctrl);
		check_byte(drive_lines(), ~ctrl, "drive outputs");
	end
	reg_write(REG_DRIVE_CTRL, 8'h00);
	check_byte(drive_lines(), 8'hFF, "drive outputs released");
endtask

task automatic test_pointer();
	sram_addr_t ptr;
	sram_addr_t rd;
	byte_t      st;
	byte_t      flags;
	int         i;
	flags = byte_t'((1 << ST2_EMPTY) | (1 << ST2_FULL));
	for (i = 0; i < 4; i++) begin
		ptr = rand_addr();
		load_pointer(ptr);
		read_pointer(rd);
		check_addr(rd, ptr, "pointer readback");
		check_addr(sram_a, ptr, "sram_a pins");
	end
	load_pointer('0);
	reg_read(REG_STATUS2, st);
	check_byte(st & flags, byte_t'(1 << ST2_EMPTY), "flags at pointer 0");
	load_pointer('1);
	reg_read(REG_STATUS2, st);
	check_byte(st & flags, byte_t'(1 << ST2_FULL), "flags at pointer all ones");
endtask

task automatic test_sram_data();
	sram_addr_t start;
	sram_addr_t ptr;
	byte_t      data [8];
	byte_t      rd;
	int         i;
	start = rand_addr();
	load_pointer(start);
	latch_addr({8'h00, REG_SRAM_DATA});
	for (i = 0; i < 8; i++) begin
		data[i] = rand_byte();
		bus_write(data[i]);	// Pointer advances after each byte
	end
	read_pointer(ptr);
	check_addr(ptr, start + sram_addr_t'(8), "pointer after 8 writes");
	load_pointer(start);
	latch_addr({8'h00, REG_SRAM_DATA});
	for (i = 0; i < 8; i++) begin
		bus_read(rd);
		check_byte(rd, data[i], "SRAM byte readback");
	end
	read_pointer(ptr);
	check_addr(ptr, start + sram_addr_t'(8), "pointer after 8 reads");
endtask

task automatic test_seek();
	byte_t st;
	int    first;
	first = track_pos;
	// Inward 3, slow rate so the second command lands mid seek
	reg_write(REG_STEP_RATE, 8'd9);
	reg_write(REG_STEP_CMD, byte_t'((1 << STEP_DIR_BIT) | 3));
	reg_write(REG_STEP_CMD, 8'd10);	// Ignored while stepping
	wait_seek_done(1'b0);
	check_byte(byte_t'(track_pos), byte_t'(first + 3), "track after inward seek");
	// Outward 20 ends early at track 0
	reg_write(REG_STEP_RATE, 8'd2);
	reg_write(REG_STEP_CMD, 8'd20);
	wait_seek_done(1'b1);
	check_byte(byte_t'(track_pos), 8'd0, "track after outward seek");
	reg_read(REG_STATUS2, st);
	check_byte(st & byte_t'(1 << ST2_TRACK0), 8'h00, "track 0 bit, active low");
	check_byte({7'b0, fd_step}, 8'h01, "fd_step idle level");
endtask

task automatic test_status_inputs();
	byte_t lv;
	byte_t st;
	byte_t expected;
	byte_t mask;
	int    i;
	mask = byte_t'((1 << ST2_INDEX) | (1 << ST2_TRACK0) | (1 << ST2_WRPROT) |
		(1 << ST2_READY) | (1 << ST2_DENSITY));
	for (i = 0; i < 6; i++) begin
		lv = rand_byte();
		@(negedge CLK_MASTER);
		fd_index_in    = lv[0];
		fd_wrprot_in   = lv[1];
		fd_rdy_dchg_in = lv[2];
		fd_dens_in     = lv[3];
		expected              = '0;
		expected[ST2_INDEX]   = lv[0];
		expected[ST2_TRACK0]  = (track_pos != 0);
		expected[ST2_WRPROT]  = lv[1];
		expected[ST2_READY]   = lv[2];
		expected[ST2_DENSITY] = lv[3];
		reg_read(REG_STATUS2, st);
		check_byte(st & mask, expected, "STATUS2 input bits");
	end
endtask

// File: testbench/tb_fdc_top.sv
`timescale 1ns/1ps

module tb_fdc_top;
	import fdc_pkg::*;

	localparam int CLK_PERIOD     = 100;	// ns
	localparam int TICK_CLKS      = 4;	// Short base tick for simulation
	localparam int STROBE_CYCLES  = 6;	// MCU strobe high and low time
	// Whole run is a few thousand cycles, seeks included
	localparam int TIMEOUT_CYCLES = 20000;

	logic       CLK_MASTER;
	logic       rst_n;
	logic       mcu_pmalh;
	logic       mcu_pmall;
	logic       mcu_pmrd;
	logic       mcu_pmwr;
	logic       fd_index_in;
	logic       fd_track0_in;
	logic       fd_wrprot_in;
	logic       fd_rdy_dchg_in;
	logic       fd_dens_in;
	wire byte_t mcu_pmd;
	wire byte_t sram_dq;
	sram_addr_t sram_a;
	logic       sram_we_n;
	logic       sram_oe_n;
	logic       fd_step;
	logic       fd_dir;
	logic       fd_dens_out;
	logic       fd_inuse;
	logic [3:0] fd_drvsel;
	logic       fd_moten;
	logic       fd_sidesel;

	byte_t       pmd_drv;		// MCU side of the data bus
	logic        pmd_en;
	logic [31:0] lfsr_state = 32'h8d1f2091;
	int          cycle_count = 0;
	int          track_pos = 5;	// Head starts off track 0
	byte_t       sram_mem [0:(1 << 19) - 1];

	////////////////////////////////////////////////////////////
	// Clock and DUT
	initial CLK_MASTER = 1'b0;
	always #(CLK_PERIOD / 2) CLK_MASTER = ~CLK_MASTER;

	fdc_top #(
		.clks_per_tick (TICK_CLKS)
	) fdc_top_inst (
		.CLK_MASTER     (CLK_MASTER),
		.rst_n          (rst_n),
		.mcu_pmalh      (mcu_pmalh),
		.mcu_pmall      (mcu_pmall),
		.mcu_pmrd       (mcu_pmrd),
		.mcu_pmwr       (mcu_pmwr),
		.fd_index_in    (fd_index_in),
		.fd_track0_in   (fd_track0_in),
		.fd_wrprot_in   (fd_wrprot_in),
		.fd_rdy_dchg_in (fd_rdy_dchg_in),
		.fd_dens_in     (fd_dens_in),
		.mcu_pmd        (mcu_pmd),
		.sram_dq        (sram_dq),
		.sram_a         (sram_a),
		.sram_we_n      (sram_we_n),
		.sram_oe_n      (sram_oe_n),
		.fd_step        (fd_step),
		.fd_dir         (fd_dir),
		.fd_dens_out    (fd_dens_out),
		.fd_inuse       (fd_inuse),
		.fd_drvsel      (fd_drvsel),
		.fd_moten       (fd_moten),
		.fd_sidesel     (fd_sidesel)
	);

	assign mcu_pmd = pmd_en ? pmd_drv : 'z;	// Released during reads

	////////////////////////////////////////////////////////////
	// SRAM and drive models
	assign sram_dq = !sram_oe_n ? sram_mem[sram_a] : 'z;

	always @(posedge sram_we_n) begin
		if (rst_n === 1'b1)
			sram_mem[sram_a] = sram_dq;	// Byte taken at end of WE pulse
	end

	// One track per step pulse, dir low moves inward
	always @(negedge fd_step) begin
		if (rst_n === 1'b1) begin
			if (!fd_dir)
				track_pos = track_pos + 1;
			else
				track_pos = track_pos - 1;	// Goes below 0 on an overshoot
		end
	end

	assign fd_track0_in = (track_pos != 0);	// Active low

	////////////////////////////////////////////////////////////
	// LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic byte_t rand_byte();
		byte_t b;
		int    i;
		for (i = 0; i < 8; i++)
			b[i] = lfsr_bit();
		return b;
	endfunction

	function automatic sram_addr_t rand_addr();
		sram_addr_t a;
		int         i;
		for (i = 0; i < 19; i++)
			a[i] = lfsr_bit();
		return a;
	endfunction

	// Drive lines packed like the control register
	function automatic byte_t drive_lines();
		return {fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out};
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, got %02h, expected %02h",
				$time, what, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input sram_addr_t actual, input sram_addr_t expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, got %05h, expected %05h",
				$time, what, actual, expected);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("At %0t ns the run stopped: %s", $time, why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// Run limit
	always @(posedge CLK_MASTER) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run("the tests did not finish within the cycle limit");
	end

	`include "tb_fdc_tests.svh"

	////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		rst_n          = 1'b0;
		mcu_pmalh      = 1'b0;
		mcu_pmall      = 1'b0;
		mcu_pmrd       = 1'b0;
		mcu_pmwr       = 1'b0;
		pmd_drv        = '0;
		pmd_en         = 1'b0;
		fd_index_in    = 1'b1;
		fd_wrprot_in   = 1'b1;
		fd_rdy_dchg_in = 1'b1;
		fd_dens_in     = 1'b0;
		repeat (2) @(posedge CLK_MASTER);
		@(negedge CLK_MASTER);
		rst_n = 1'b1;

		test_identity();
		test_drive_ctrl();
		test_pointer();
		test_sram_data();
		test_seek();
		test_status_inputs();

		if (fdc_top_inst.fdc_top_assert_inst.violations == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("%0d bound assertion failures were seen",
				fdc_top_inst.fdc_top_assert_inst.violations);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

endmodule
